// ==== project.f ====
+incdir+.
mmu_pkg.sv
mmu_reg_port.sv
mmu_apr_bank.sv
mmu_translate.sv
mmu_top.sv
tb_mmu.sv

// ==== run.sh ====
#!/bin/sh
# build tb_mmu with Verilator, run it, exit status follows the pass line
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_mmu || exit 1
out=$(./obj_dir/Vtb_mmu 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Regression passed" && exit 0 || exit 1

// ==== tb_mmu_checks.svh ====
// stimulus table and check helpers for tb_mmu, included inside the module body
// expected MMR0 words are octal, en bit stays set after every clear write
`ifndef TB_MMU_CHECKS_SVH
`define TB_MMU_CHECKS_SVH

typedef enum logic [1:0] {OP_CW, OP_CR, OP_RD, OP_WR} op_t;

typedef struct packed {
   op_t    op;
   word_t  adr;    // config offset or virtual address
   mode_t  mode;
   word_t  dat;    // write data
   paddr_t pa;     // expected mem_adr_o
   logic   abort;  // expected mmu_abort_o
   word_t  rd;     // expected cfg_dat_o
} row_t;

localparam int TIMEOUT = 40;  // cycles per wait
localparam int N_ROWS  = 44;

//**************************************************
// op, adr, mode, dat, pa, abort, rd
//**************************************************
localparam row_t ROWS [N_ROWS] = '{
   // reset value, then MMU off
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o000000},
   '{OP_RD, 16'o012346, MODE_KERNEL,  16'o000000, 18'o012346, 1'b0, 16'o000000},
   '{OP_WR, 16'o160100, MODE_USER,    16'o000000, 18'o760100, 1'b0, 16'o000000},
   // page 1 of each mode, PDR written with junk in the zero and A/W bits
   '{OP_CW, 16'o002342, MODE_KERNEL,  16'o001000, 18'o000000, 1'b0, 16'o000000},
   '{OP_CW, 16'o002302, MODE_KERNEL,  16'o177766, 18'o000000, 1'b0, 16'o000000},
   '{OP_CW, 16'o002242, MODE_KERNEL,  16'o002000, 18'o000000, 1'b0, 16'o000000},
   '{OP_CW, 16'o002202, MODE_KERNEL,  16'o177766, 18'o000000, 1'b0, 16'o000000},
   '{OP_CW, 16'o017642, MODE_KERNEL,  16'o003000, 18'o000000, 1'b0, 16'o000000},
   '{OP_CW, 16'o017602, MODE_KERNEL,  16'o177766, 18'o000000, 1'b0, 16'o000000},
   '{OP_CR, 16'o002342, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o001000},
   '{OP_CR, 16'o002302, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o077406},
   '{OP_CR, 16'o002242, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o002000},
   '{OP_CR, 16'o002202, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o077406},
   '{OP_CR, 16'o017642, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o003000},
   '{OP_CR, 16'o017602, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o077406},
   '{OP_CR, 16'o000000, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o000000},
   // MMR0 keeps only en and the error bits
   '{OP_CW, 16'o017572, MODE_KERNEL,  16'o177777, 18'o000000, 1'b0, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o160001},
   '{OP_CW, 16'o017572, MODE_KERNEL,  16'o000001, 18'o000000, 1'b0, 16'o000000},
   // same address, three modes, base*64 + va[12:0]
   '{OP_RD, 16'o021234, MODE_KERNEL,  16'o000000, 18'o101234, 1'b0, 16'o000000},
   '{OP_RD, 16'o021234, MODE_SUPER,   16'o000000, 18'o201234, 1'b0, 16'o000000},
   '{OP_WR, 16'o021234, MODE_USER,    16'o000000, 18'o301234, 1'b0, 16'o000000},
   // nonresident kernel page 2, then mode 2 while frozen
   '{OP_RD, 16'o040012, MODE_KERNEL,  16'o000000, 18'o000000, 1'b1, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o100005},
   '{OP_RD, 16'o021234, MODE_ILLEGAL, 16'o000000, 18'o000000, 1'b1, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o100005},
   '{OP_CW, 16'o017572, MODE_KERNEL,  16'o000001, 18'o000000, 1'b0, 16'o000000},
   '{OP_RD, 16'o021234, MODE_ILLEGAL, 16'o000000, 18'o000000, 1'b1, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o100103},
   '{OP_CW, 16'o017572, MODE_KERNEL,  16'o000001, 18'o000000, 1'b0, 16'o000000},
   // super page 3 grows up, length 4
   '{OP_CW, 16'o002206, MODE_KERNEL,  16'o002006, 18'o000000, 1'b0, 16'o000000},
   '{OP_RD, 16'o060400, MODE_SUPER,   16'o000000, 18'o000400, 1'b0, 16'o000000},
   '{OP_RD, 16'o060500, MODE_SUPER,   16'o000000, 18'o000000, 1'b1, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o040047},
   '{OP_CW, 16'o017572, MODE_KERNEL,  16'o000001, 18'o000000, 1'b0, 16'o000000},
   // user page 4 grows down, length 120
   '{OP_CW, 16'o017610, MODE_KERNEL,  16'o074016, 18'o000000, 1'b0, 16'o000000},
   '{OP_RD, 16'o117700, MODE_USER,    16'o000000, 18'o017700, 1'b0, 16'o000000},
   '{OP_RD, 16'o116700, MODE_USER,    16'o000000, 18'o000000, 1'b1, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o040151},
   '{OP_CW, 16'o017572, MODE_KERNEL,  16'o000001, 18'o000000, 1'b0, 16'o000000},
   // kernel page 5 read-only
   '{OP_CW, 16'o002312, MODE_KERNEL,  16'o077402, 18'o000000, 1'b0, 16'o000000},
   '{OP_RD, 16'o120100, MODE_KERNEL,  16'o000000, 18'o000100, 1'b0, 16'o000000},
   '{OP_WR, 16'o120100, MODE_KERNEL,  16'o000000, 18'o000000, 1'b1, 16'o000000},
   '{OP_CR, 16'o017572, MODE_KERNEL,  16'o000000, 18'o000000, 1'b0, 16'o020013}
};

task automatic stop_run();
   $display("Regression failed");
   $fatal(1, "run stopped at the first failure");
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
   if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %06o actual %06o", $time, name, exp, act);
      stop_run();
   end
endtask

task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
   if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %06o actual %06o", $time, name, exp, act);
      stop_run();
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %0b actual %0b", $time, name, exp, act);
      stop_run();
   end
endtask

//**************************************************
// waits, all sampled on the falling edge
//**************************************************
task automatic count_cycle(inout int n, input string what);
   @(negedge clk);
   n++;
   if (n > TIMEOUT) begin
      $display("timeout, %s did not happen within %0d cycles", what, TIMEOUT);
      stop_run();
   end
endtask

task automatic wait_cfg_ack(input logic level);
   int n;
   n = 0;
   do count_cycle(n, "config ack change"); while (cfg_ack_o !== level);
endtask

task automatic wait_mem_stb();
   int n;
   n = 0;
   do count_cycle(n, "memory strobe"); while (mem_stb_o !== 1'b1);
endtask

task automatic wait_cpu_reply();
   int n;
   n = 0;
   do count_cycle(n, "CPU ack or abort"); while (cpu_ack_o !== 1'b1 && mmu_abort_o !== 1'b1);
endtask

task automatic wait_cpu_release();
   int n;
   n = 0;
   do count_cycle(n, "CPU reply release"); while (cpu_ack_o !== 1'b0 || mmu_abort_o !== 1'b0);
endtask

`endif

// ==== tb_mmu.sv ====
// testbench for mmu_top, rows of the table in tb_mmu_checks.svh run in order
// memory answers after a random 0..5 cycle gap, run stops at the first mismatch
`timescale 1ns/10ps

module tb_mmu import mmu_pkg::*; ();

   localparam logic [31:0] SEED = 32'he162baf9;

   logic             clk = 1'b0;
   logic             reset;
   logic             cfg_stb_i;
   logic             cfg_we_i;
   logic [OFS_W-1:0] cfg_adr_i;
   word_t            cfg_dat_i;
   logic             cfg_ack_o;
   word_t            cfg_dat_o;
   logic             cpu_stb_i;
   logic             cpu_we_i;
   vaddr_t           cpu_adr_i;
   mode_t            cpu_mode_i;
   logic             cpu_ack_o;
   logic             mmu_abort_o;
   logic             mem_stb_o;
   paddr_t           mem_adr_o;
   logic             mem_ack_i = 1'b0;  // responder only
   int               mem_cycles = 0;    // strobes seen by the responder
   int               mem_acks = 0;      // acks it gave
   int               mem_gap = 0;       // cycles before the memory ack

   `include "tb_mmu_checks.svh"

   always #20 clk = ~clk;  // 40 ns

   mmu_top mmu_top_inst (
      .clk         (clk),
      .reset       (reset),
      .cfg_stb_i   (cfg_stb_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_adr_i   (cfg_adr_i),
      .cfg_dat_i   (cfg_dat_i),
      .cfg_ack_o   (cfg_ack_o),
      .cfg_dat_o   (cfg_dat_o),
      .cpu_stb_i   (cpu_stb_i),
      .cpu_we_i    (cpu_we_i),
      .cpu_adr_i   (cpu_adr_i),
      .cpu_mode_i  (cpu_mode_i),
      .cpu_ack_o   (cpu_ack_o),
      .mmu_abort_o (mmu_abort_o),
      .mem_stb_o   (mem_stb_o),
      .mem_adr_o   (mem_adr_o),
      .mem_ack_i   (mem_ack_i)
   );

   //**************************************************
   // memory model, ack held until the strobe drops
   //**************************************************
   always begin : mem_responder
      int n;
      @(negedge clk);
      if (mem_stb_o && !mem_ack_i) begin
         mem_cycles++;
         repeat (mem_gap) @(negedge clk);
         @(posedge clk);
         mem_ack_i <= 1'b1;
         mem_acks++;
         n = 0;
         do count_cycle(n, "memory strobe drop"); while (mem_stb_o);
         @(posedge clk);
         mem_ack_i <= 1'b0;
      end
   end

   // one register access, full four-phase cycle
   task automatic cfg_access(input row_t r);
      @(posedge clk);
      cfg_stb_i <= 1'b1;
      cfg_we_i  <= (r.op == OP_CW);
      cfg_adr_i <= r.adr[OFS_W-1:0];
      cfg_dat_i <= r.dat;
      wait_cfg_ack(1'b1);
      if (r.op == OP_CR) check_word("cfg_dat_o", r.rd, cfg_dat_o);
      @(posedge clk);
      cfg_stb_i <= 1'b0;
      wait_cfg_ack(1'b0);
   endtask

   // one translated access, ends with ack or abort released
   task automatic cpu_access(input row_t r);
      int cyc0;
      int ack0;
      cyc0 = mem_cycles;
      ack0 = mem_acks;
      mem_gap = $urandom_range(5, 0);  // memory delay for this access
      @(posedge clk);
      cpu_stb_i  <= 1'b1;
      cpu_we_i   <= (r.op == OP_WR);
      cpu_adr_i  <= r.adr;
      cpu_mode_i <= r.mode;
      if (!r.abort) begin
         wait_mem_stb();
         check_paddr("mem_adr_o", r.pa, mem_adr_o);  // address while stb is up
      end
      wait_cpu_reply();
      check_flag("mmu_abort_o", r.abort, mmu_abort_o);
      check_flag("cpu_ack_o", ~r.abort, cpu_ack_o);
      check_flag("mem_stb_o", 1'b0, mem_stb_o);  // down with the reply
      check_flag("mem_stb_o cycle", ~r.abort, mem_cycles != cyc0);  // none on abort
      check_flag("mem_ack_i before cpu_ack_o", ~r.abort, mem_acks != ack0);
      @(posedge clk);
      cpu_stb_i <= 1'b0;
      wait_cpu_release();
   endtask

   initial begin
      void'($urandom(SEED));
      reset      = 1'b1;
      cfg_stb_i  = 1'b0;
      cfg_we_i   = 1'b0;
      cfg_adr_i  = '0;
      cfg_dat_i  = '0;
      cpu_stb_i  = 1'b0;
      cpu_we_i   = 1'b0;
      cpu_adr_i  = '0;
      cpu_mode_i = MODE_KERNEL;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      // outputs quiet after reset
      check_flag("cfg_ack_o", 1'b0, cfg_ack_o);
      check_flag("cpu_ack_o", 1'b0, cpu_ack_o);
      check_flag("mmu_abort_o", 1'b0, mmu_abort_o);
      check_flag("mem_stb_o", 1'b0, mem_stb_o);
      for (int i = 0; i < N_ROWS; i++) begin
         if (ROWS[i].op == OP_CW || ROWS[i].op == OP_CR) cfg_access(ROWS[i]);
         else cpu_access(ROWS[i]);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

// ==== mmu_top.sv ====
// MMU top, register port, three mode banks and the translator
// kernel, supervisor and user banks sit at generate index 0, 1, 2
`timescale 1ns/10ps

module mmu_top import mmu_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   // config port
   input  logic             cfg_stb_i,
   input  logic             cfg_we_i,
   input  logic [OFS_W-1:0] cfg_adr_i,
   input  word_t            cfg_dat_i,
   output logic             cfg_ack_o,
   output word_t            cfg_dat_o,
   // CPU port
   input  logic             cpu_stb_i,
   input  logic             cpu_we_i,
   input  vaddr_t           cpu_adr_i,
   input  mode_t            cpu_mode_i,
   output logic             cpu_ack_o,
   output logic             mmu_abort_o,
   // memory side
   output logic             mem_stb_o,
   output paddr_t           mem_adr_o,
   input  logic             mem_ack_i
);

   logic [N_BANKS-1:0]  bank_we;
   logic                sel_par;
   page_t               wr_page;   // also the readback page
   apr_word_u           wr_dat;
   logic                mmr0_we;
   word_t               mmr0;
   word_t [N_BANKS-1:0] rd_par;
   pdr_t  [N_BANKS-1:0] rd_pdr;
   word_t [N_BANKS-1:0] xlat_par;
   pdr_t  [N_BANKS-1:0] xlat_pdr;

   mmu_reg_port u_reg_port (
      .clk        (clk),
      .reset      (reset),
      .cfg_stb_i  (cfg_stb_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_adr_i  (cfg_adr_i),
      .cfg_dat_i  (cfg_dat_i),
      .cfg_ack_o  (cfg_ack_o),
      .cfg_dat_o  (cfg_dat_o),
      .bank_par_i (rd_par),
      .bank_pdr_i (rd_pdr),
      .mmr0_i     (mmr0),
      .bank_we_o  (bank_we),
      .sel_par_o  (sel_par),
      .wr_page_o  (wr_page),
      .wr_dat_o   (wr_dat),
      .mmr0_we_o  (mmr0_we)
   );

   //**************************************************
   // one bank per processor mode
   //**************************************************
   for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
      localparam mode_t MODE_G = (g == 0) ? MODE_KERNEL :
                                 (g == 1) ? MODE_SUPER  : MODE_USER;
      mmu_apr_bank #(.BANK_MODE(MODE_G)) u_bank (
         .clk         (clk),
         .reset       (reset),
         .we_i        (bank_we[g]),
         .sel_par_i   (sel_par),
         .wr_page_i   (wr_page),
         .wr_dat_i    (wr_dat),
         .rd_page_i   (wr_page),
         .xlat_page_i (cpu_adr_i[15:13]),
         .rd_par_o    (rd_par[g]),
         .rd_pdr_o    (rd_pdr[g]),
         .xlat_par_o  (xlat_par[g]),
         .xlat_pdr_o  (xlat_pdr[g])
      );
   end

   mmu_translate u_translate (
      .clk         (clk),
      .reset       (reset),
      .cpu_stb_i   (cpu_stb_i),
      .cpu_we_i    (cpu_we_i),
      .cpu_adr_i   (cpu_adr_i),
      .cpu_mode_i  (cpu_mode_i),
      .cpu_ack_o   (cpu_ack_o),
      .mmu_abort_o (mmu_abort_o),
      .bank_par_i  (xlat_par),
      .bank_pdr_i  (xlat_pdr),
      .mmr0_we_i   (mmr0_we),
      .mmr0_dat_i  (cfg_dat_i),
      .mmr0_o      (mmr0),
      .mem_stb_o   (mem_stb_o),
      .mem_adr_o   (mem_adr_o),
      .mem_ack_i   (mem_ack_i)
   );

endmodule

// ==== mmu_translate.sv ====
// 16 to 18 bit relocation, fault checks, MMR0 and the memory cycle
// CPU holds stb until ack or abort, memory ack may come at any time
`timescale 1ns/10ps

module mmu_translate import mmu_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               cpu_stb_i,
   input  logic               cpu_we_i,
   input  vaddr_t             cpu_adr_i,
   input  mode_t              cpu_mode_i,
   output logic               cpu_ack_o,
   output logic               mmu_abort_o,
   input  word_t [N_BANKS-1:0] bank_par_i,  // pair for the CPU page, per bank
   input  pdr_t  [N_BANKS-1:0] bank_pdr_i,
   input  logic               mmr0_we_i,
   input  word_t              mmr0_dat_i,
   output word_t              mmr0_o,
   output logic               mem_stb_o,
   output paddr_t             mem_adr_o,
   input  logic               mem_ack_i
);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_MEM   = 2'd1;  // waiting on memory
   localparam logic [1:0] S_REPLY = 2'd2;  // ack or abort held

   logic [1:0]  state;
   word_t       mmr0_q;
   word_t       par;
   pdr_t        pdr;
   page_t       page;
   logic [6:0]  blk;        // block inside the page
   logic [11:0] phys_blk;   // 64-byte block number
   paddr_t      paddr;
   logic        mmu_en;
   logic        mode_bad;
   logic        flt_nr, flt_pl, flt_ro;
   logic        fault;
   logic        frozen;

   assign page     = cpu_adr_i[15:13];
   assign blk      = cpu_adr_i[12:6];
   assign mmu_en   = mmr0_q[MMR0_EN];
   assign mode_bad = (cpu_mode_i == MODE_ILLEGAL);
   assign par      = bank_par_i[bank_index(cpu_mode_i)];
   assign pdr      = bank_pdr_i[bank_index(cpu_mode_i)];

   //**************************************************
   // relocation
   //**************************************************
   assign phys_blk = par[11:0] + {5'b0, blk};  // wraps at 256 KB
   always_comb begin
      if (mmu_en) paddr = {phys_blk, cpu_adr_i[5:0]};
      else if (page == 3'd7) paddr = IOPAGE_BASE | paddr_t'(cpu_adr_i[12:0]);
      else paddr = paddr_t'(cpu_adr_i);  // plain 16-bit space
   end

   // faults, only with relocation on
   assign flt_nr = mmu_en & (mode_bad |
                   (pdr.acf inside {ACF_NONRES0, ACF_NONRES3, ACF_NONRES7}));
   assign flt_pl = mmu_en & ~mode_bad &
                   (pdr.ed ? (blk < pdr.plf) : (blk > pdr.plf));
   assign flt_ro = mmu_en & ~mode_bad & cpu_we_i & (pdr.acf inside {ACF_RO1, ACF_RO2});
   assign fault  = flt_nr | flt_pl | flt_ro;
   assign frozen = |mmr0_q[MMR0_ERR_RO +: 3];  // fields hold until cleared

   //**************************************************
   // request FSM and MMR0
   //**************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= S_IDLE;
         cpu_ack_o   <= 1'b0;
         mmu_abort_o <= 1'b0;
         mem_stb_o   <= 1'b0;
         mmr0_q      <= '0;  // relocation off
      end else begin
         case (state)
            S_IDLE: if (cpu_stb_i) begin
               if (fault) begin
                  mmu_abort_o <= 1'b1;  // no memory cycle
                  state       <= S_REPLY;
                  if (!frozen) begin
                     mmr0_q[MMR0_ERR_NR]        <= flt_nr;
                     mmr0_q[MMR0_ERR_PL]        <= flt_pl;
                     mmr0_q[MMR0_ERR_RO]        <= flt_ro;
                     mmr0_q[MMR0_MODE_LSB +: 2] <= cpu_mode_i;
                     mmr0_q[MMR0_PAGE_LSB +: 3] <= page;
                  end
               end else begin
                  mem_stb_o <= 1'b1;
                  state     <= S_MEM;
               end
            end
            S_MEM: if (mem_ack_i) begin
               mem_stb_o <= 1'b0;
               cpu_ack_o <= 1'b1;
               state     <= S_REPLY;
            end
            S_REPLY: if (!cpu_stb_i) begin
               cpu_ack_o   <= 1'b0;
               mmu_abort_o <= 1'b0;
               state       <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
         // software write wins over a fault in the same cycle
         if (mmr0_we_i) begin
            mmr0_q[MMR0_EN]          <= mmr0_dat_i[MMR0_EN];
            mmr0_q[MMR0_ERR_RO +: 3] <= mmr0_dat_i[MMR0_ERR_RO +: 3];
         end
      end
   end

   // address held for the whole memory cycle
   always_ff @(posedge clk) begin
      if (state == S_IDLE && cpu_stb_i && !fault) mem_adr_o <= paddr;
   end

   assign mmr0_o = mmr0_q;

   a_stb_abort: assert property (@(posedge clk) disable iff (reset)
      !(mem_stb_o && mmu_abort_o));
   // CPU reply follows a memory ack by one cycle with the strobe already down
   a_ack_mem: assert property (@(posedge clk) disable iff (reset)
      $rose(cpu_ack_o) |-> $past(mem_stb_o && mem_ack_i) && !mem_stb_o && !mmu_abort_o);

endmodule

// ==== mmu_apr_bank.sv ====
// eight PAR/PDR pairs of one processor mode
// write port plus two combinational read ports, config and translation
`timescale 1ns/10ps

module mmu_apr_bank import mmu_pkg::*; #(
   parameter mode_t BANK_MODE = MODE_KERNEL
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      we_i,
   input  logic      sel_par_i,    // 1 = PAR, 0 = PDR
   input  page_t     wr_page_i,
   input  apr_word_u wr_dat_i,
   input  page_t     rd_page_i,    // config readback
   input  page_t     xlat_page_i,  // virtual bits 15..13
   output word_t     rd_par_o,
   output pdr_t      rd_pdr_o,
   output word_t     xlat_par_o,
   output pdr_t      xlat_pdr_o
);

   word_t par_mem [N_PAGES];
   pdr_t  pdr_mem [N_PAGES];

   //**************************************************
   // register write
   //**************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < N_PAGES; i++) begin
            par_mem[i] <= '0;
            pdr_mem[i] <= '0;  // acf 0, page nonresident
         end
      end else if (we_i) begin
         if (sel_par_i) par_mem[wr_page_i] <= wr_dat_i.par;
         else           pdr_mem[wr_page_i] <= wr_dat_i.pdr;
      end
   end

   // readback port
   assign rd_par_o   = par_mem[rd_page_i];
   assign rd_pdr_o   = pdr_mem[rd_page_i];
   // translation port
   assign xlat_par_o = par_mem[xlat_page_i];
   assign xlat_pdr_o = pdr_mem[xlat_page_i];

   a_wr_page_known: assert property (@(posedge clk) disable iff (reset)
      we_i |-> !$isunknown(wr_page_i))
      else $error("bank %0d written with unknown page", bank_index(BANK_MODE));

endmodule

// ==== mmu_reg_port.sv ====
// configuration port for PAR/PDR and MMR0, four-phase strobe/ack
// master holds address and data until ack, unmatched offsets read zero
`timescale 1ns/10ps

module mmu_reg_port import mmu_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cfg_stb_i,
   input  logic                   cfg_we_i,
   input  logic [OFS_W-1:0]       cfg_adr_i,
   input  word_t                  cfg_dat_i,
   output logic                   cfg_ack_o,
   output word_t                  cfg_dat_o,
   input  word_t [N_BANKS-1:0]    bank_par_i,   // selected pair per bank
   input  pdr_t  [N_BANKS-1:0]    bank_pdr_i,
   input  word_t                  mmr0_i,
   output logic  [N_BANKS-1:0]    bank_we_o,
   output logic                   sel_par_o,    // 1 = PAR, 0 = PDR
   output page_t                  wr_page_o,
   output apr_word_u              wr_dat_o,
   output logic                   mmr0_we_o
);

   // base offsets in bank order
   localparam logic [OFS_W-1:0] PDR_OFS [N_BANKS] = '{KPDR_OFS, SPDR_OFS, UPDR_OFS};
   localparam logic [OFS_W-1:0] PAR_OFS [N_BANKS] = '{KPAR_OFS, SPAR_OFS, UPAR_OFS};

   logic               ack_q;
   logic               go;        // strobe seen, ack not yet up
   logic [N_BANKS-1:0] hit_bank;
   logic               hit_par;
   logic               hit_mmr0;
   apr_word_u          rd_u;
   word_t              rd_word;
   word_t              dat_q;

   //**************************************************
   // address decode
   //**************************************************
   always_comb begin
      hit_bank = '0;
      hit_par  = 1'b0;
      for (int b = 0; b < N_BANKS; b++) begin
         if (cfg_adr_i[OFS_W-1:4] == PDR_OFS[b][OFS_W-1:4] && !cfg_adr_i[0]) begin
            hit_bank[b] = 1'b1;
         end
         if (cfg_adr_i[OFS_W-1:4] == PAR_OFS[b][OFS_W-1:4] && !cfg_adr_i[0]) begin
            hit_bank[b] = 1'b1;
            hit_par     = 1'b1;
         end
      end
   end

   assign hit_mmr0  = (cfg_adr_i == MMR0_OFS);
   assign wr_page_o = cfg_adr_i[3:1];  // word index in the group of 8
   assign sel_par_o = hit_par;
   assign wr_dat_o  = apr_word_u'(cfg_dat_i);

   // writes land on the edge where ack rises
   assign go        = cfg_stb_i & ~ack_q;
   assign bank_we_o = hit_bank & {N_BANKS{go & cfg_we_i}};
   assign mmr0_we_o = hit_mmr0 & go & cfg_we_i;

   // read mux, PDR goes through the union to get masked as a word
   always_comb begin
      rd_word = '0;
      rd_u    = '0;
      for (int b = 0; b < N_BANKS; b++) begin
         if (hit_bank[b]) begin
            rd_u.pdr = bank_pdr_i[b];
            rd_word  = hit_par ? bank_par_i[b] : (rd_u.par & PDR_MASK);
         end
      end
      if (hit_mmr0) rd_word = mmr0_i;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= cfg_stb_i;  // up one cycle after stb, down one after it drops
      end
   end

   always_ff @(posedge clk) begin
      if (go) dat_q <= rd_word;  // held for the whole ack phase
   end

   assign cfg_ack_o = ack_q;
   assign cfg_dat_o = dat_q;

   // a write hits exactly one register and the ack rises next
   a_we_ack: assert property (@(posedge clk) disable iff (reset)
      (|bank_we_o || mmr0_we_o) |=> $rose(cfg_ack_o) && $onehot($past({bank_we_o, mmr0_we_o})));

endmodule

// ==== mmu_pkg.sv ====
// widths, types and register map of the 18-bit mapping MMU
// offsets are byte offsets inside the 8 KB I/O page, word aligned
package mmu_pkg;

   localparam int VA_W    = 16;  // virtual address
   localparam int PA_W    = 18;  // physical address
   localparam int OFS_W   = 13;  // I/O page offset
   localparam int N_PAGES = 8;   // pages per mode
   localparam int N_BANKS = 3;   // kernel, supervisor, user

   typedef logic [15:0]     word_t;
   typedef logic [VA_W-1:0] vaddr_t;
   typedef logic [PA_W-1:0] paddr_t;
   typedef logic [2:0]      page_t;
   typedef logic [1:0]      mode_t;

   localparam mode_t MODE_KERNEL  = 2'd0;
   localparam mode_t MODE_SUPER   = 2'd1;
   localparam mode_t MODE_ILLEGAL = 2'd2;  // selects no bank
   localparam mode_t MODE_USER    = 2'd3;

   // access-control field of a PDR
   typedef enum logic [2:0] {
      ACF_NONRES0 = 3'd0,
      ACF_RO1     = 3'd1,  // read-only
      ACF_RO2     = 3'd2,  // read-only
      ACF_NONRES3 = 3'd3,
      ACF_RW4     = 3'd4,  // read/write
      ACF_RW5     = 3'd5,
      ACF_RW6     = 3'd6,
      ACF_NONRES7 = 3'd7
   } acf_t;

   typedef struct packed {
      logic       zero_hi;   // bit 15
      logic [6:0] plf;       // page length in 64-byte blocks
      logic [3:0] zero_mid;  // A and W bits, not kept here
      logic       ed;        // 1 = page grows downward
      acf_t       acf;
   } pdr_t;

   // one register word, seen as a PAR or as a PDR
   typedef union packed {
      word_t par;  // low 12 bits hold the base block number
      pdr_t  pdr;
   } apr_word_u;

   localparam word_t PDR_MASK = 16'o077417;  // plf, ed, acf

   //**************************************************
   // register offsets in the I/O page
   //**************************************************
   localparam logic [OFS_W-1:0] KPDR_OFS = 13'o02300;
   localparam logic [OFS_W-1:0] KPAR_OFS = 13'o02340;
   localparam logic [OFS_W-1:0] SPDR_OFS = 13'o02200;
   localparam logic [OFS_W-1:0] SPAR_OFS = 13'o02240;
   localparam logic [OFS_W-1:0] UPDR_OFS = 13'o17600;
   localparam logic [OFS_W-1:0] UPAR_OFS = 13'o17640;
   localparam logic [OFS_W-1:0] MMR0_OFS = 13'o17572;

   // MMR0 layout
   localparam int MMR0_EN       = 0;   // relocation on
   localparam int MMR0_PAGE_LSB = 1;   // page of the fault, 3 bits
   localparam int MMR0_MODE_LSB = 5;   // mode of the fault, 2 bits
   localparam int MMR0_ERR_RO   = 13;  // write to read-only page
   localparam int MMR0_ERR_PL   = 14;  // page length
   localparam int MMR0_ERR_NR   = 15;  // nonresident

   localparam paddr_t IOPAGE_BASE = 18'o760000;

   // mode to bank number, illegal mode lands on bank 0
   function automatic logic [1:0] bank_index(input mode_t mode);
      case (mode)
         MODE_SUPER: return 2'd1;
         MODE_USER:  return 2'd2;
         default:    return 2'd0;
      endcase
   endfunction

endpackage
